/* design/subsys_pkg.sv */
/*
 * Shared types and constants of the memory-mapped request subsystem.
 * Holds the address map, the single-beat bus structs, the routing target
 * enum and the sizes used by the queue, timer and debug gate.
 * Modules import it inside their body and use scoped names in their ports.
 */
package subsys_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned NrHarts   = 4;
  localparam int unsigned HartIdxW  = $clog2(NrHarts);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [NrHarts-1:0]   hart_vec_t;
  typedef logic [DataWidth-1:0] mtime_t;

  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_SPM,
    TGT_TIMER,
    TGT_NONE
  } target_e;

  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic  valid;
    logic  err;
    data_t rdata;
  } bus_resp_t;

  // ------------------------------------------------------------
  // address map
  // ------------------------------------------------------------
  localparam addr_t RomBase     = 32'h0000_1000;
  localparam addr_t RomLength   = 32'h0000_1000;
  localparam addr_t SpmBase     = 32'h8000_0000;
  localparam addr_t SpmLength   = 32'h0000_0400;
  localparam addr_t TimerBase   = 32'h0200_0000;
  localparam addr_t TimerLength = 32'h0000_0020;

  localparam int unsigned RomIdxW  = $clog2(RomLength / 4);
  localparam int unsigned SpmWords = SpmLength / 4;
  localparam int unsigned SpmIdxW  = $clog2(SpmWords);

  localparam data_t RomTag = 32'hB007_0000; // rom word i reads RomTag + i

  // timer register window
  localparam int unsigned TimerOffW = $clog2(TimerLength);
  localparam logic [TimerOffW-1:0] TimerMtimeOff = 5'h00;
  localparam logic [TimerOffW-1:0] TimerCmpOff   = 5'h04;
  localparam int unsigned TimerCmpEnd = TimerCmpOff + 4 * NrHarts;

  // ------------------------------------------------------------
  // flow control and boot delay
  // ------------------------------------------------------------
  localparam int unsigned RespDepth        = 4;
  localparam int unsigned QPtrW            = $clog2(RespDepth);
  localparam int unsigned QCntW            = $clog2(RespDepth + 1);
  localparam int unsigned DebugDelayCycles = 64;
  localparam int unsigned DebugCntW        = $clog2(DebugDelayCycles + 1);

endpackage

/* design/req_router.sv */
/*
 * Address decoder for the single-beat request bus.
 * Steers each request to one target and, one cycle later, builds the
 * response from that target's read data and error flags.
 */
`timescale 1ns/1ps

module req_router (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  subsys_pkg::bus_req_t  req_i,
  input  subsys_pkg::data_t     rom_rdata_i,
  input  subsys_pkg::data_t     spm_rdata_i,
  input  subsys_pkg::data_t     timer_rdata_i,
  input  logic                  timer_err_i,
  output subsys_pkg::bus_req_t  rom_req_o,
  output subsys_pkg::bus_req_t  spm_req_o,
  output subsys_pkg::bus_req_t  timer_req_o,
  output subsys_pkg::bus_resp_t resp_o
);
  import subsys_pkg::*;

  target_e tgt_d, tgt_q;
  logic    valid_q;
  logic    we_q;
  logic    rom_we_err_q;

  function automatic logic in_window(addr_t addr, addr_t base, addr_t len);
    return (addr >= base) && ((addr - base) < len);
  endfunction

  always_comb begin
    if (in_window(req_i.addr, RomBase, RomLength)) begin
      tgt_d = TGT_ROM;
    end else if (in_window(req_i.addr, SpmBase, SpmLength)) begin
      tgt_d = TGT_SPM;
    end else if (in_window(req_i.addr, TimerBase, TimerLength)) begin
      tgt_d = TGT_TIMER;
    end else begin
      tgt_d = TGT_NONE;
    end
  end

  always_comb begin
    rom_req_o         = req_i;
    spm_req_o         = req_i;
    timer_req_o       = req_i;
    rom_req_o.valid   = req_i.valid && (tgt_d == TGT_ROM);
    spm_req_o.valid   = req_i.valid && (tgt_d == TGT_SPM);
    timer_req_o.valid = req_i.valid && (tgt_d == TGT_TIMER);
  end

  // target stays known while its read data comes back
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q      <= 1'b0;
      tgt_q        <= TGT_NONE;
      we_q         <= 1'b0;
      rom_we_err_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
      if (req_i.valid) begin
        tgt_q        <= tgt_d;
        we_q         <= req_i.we;
        rom_we_err_q <= (tgt_d == TGT_ROM) && req_i.we;
      end
    end
  end

  always_comb begin
    data_t rdata;
    logic  err;
    case (tgt_q)
      TGT_ROM:   begin rdata = rom_rdata_i;   err = rom_we_err_q; end
      TGT_SPM:   begin rdata = spm_rdata_i;   err = 1'b0;         end
      TGT_TIMER: begin rdata = timer_rdata_i; err = timer_err_i;  end
      default:   begin rdata = '0;            err = 1'b1;         end // unmapped
    endcase
    resp_o.valid = valid_q;
    resp_o.err   = err;
    resp_o.rdata = (err || we_q) ? '0 : rdata;
  end

  a_one_target: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    $onehot0({rom_req_o.valid, spm_req_o.valid, timer_req_o.valid}));

endmodule

/* design/boot_rom.sv */
/*
 * Boot ROM with a fixed word pattern and one cycle of read latency.
 * Word i of the window returns the ROM tag plus i.
 */
`timescale 1ns/1ps

module boot_rom (
  input  logic                 clk_i,
  input  subsys_pkg::bus_req_t req_i,
  output subsys_pkg::data_t    rdata_o
);
  import subsys_pkg::*;

  logic [RomIdxW-1:0] word_idx;
  data_t              rdata_q;

  function automatic data_t rom_word(logic [RomIdxW-1:0] idx);
    return RomTag + data_t'(idx);
  endfunction

  assign word_idx = req_i.addr[RomIdxW+1:2];

  // writes only read back, the router flags them
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rdata_q <= rom_word(word_idx);
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* design/scratch_mem.sv */
/*
 * Scratchpad RAM standing in for the L2 scratchpad.
 * Word addressed, full-word writes, registered reads.
 * Content is undefined after reset.
 */
`timescale 1ns/1ps

module scratch_mem (
  input  logic                 clk_i,
  input  subsys_pkg::bus_req_t req_i,
  output subsys_pkg::data_t    rdata_o
);
  import subsys_pkg::*;

  data_t              mem_q [SpmWords];
  data_t              rdata_q;
  logic [SpmIdxW-1:0] word_idx;

  assign word_idx = req_i.addr[SpmIdxW+1:2];

  // ------------------------------------------------------------
  // single port array
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      if (req_i.we) begin
        mem_q[word_idx] <= req_i.wdata;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* design/core_timer.sv */
/*
 * Core-local timer.
 * Synchronizes the RTC input, halves its rate and counts mtime.
 * One compare register per hart raises that hart's timer interrupt.
 * Register reads and errors come back one cycle after the request.
 */
`timescale 1ns/1ps

module core_timer (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  rtc_i,
  input  subsys_pkg::bus_req_t  req_i,
  output subsys_pkg::data_t     rdata_o,
  output logic                  err_o,
  output subsys_pkg::hart_vec_t timer_irq_o
);
  import subsys_pkg::*;

  logic [1:0]          rtc_sync_q;
  logic                rtc_prev_q;
  logic                rtc_rise;
  logic                div_q;
  mtime_t              mtime_q;
  mtime_t              mtimecmp_q [NrHarts];
  hart_vec_t           timer_irq_q;
  data_t               rdata_q;
  logic                err_q;
  logic [TimerOffW-1:0] off;
  logic                is_mtime;
  logic                is_cmp;
  logic                legal;
  logic [HartIdxW-1:0] cmp_sel;

  // ------------------------------------------------------------
  // rtc path
  // ------------------------------------------------------------
  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      div_q      <= 1'b0;
      mtime_q    <= '0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        div_q <= ~div_q;
      end
      if (rtc_rise && div_q) begin // every second rising edge
        mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // register window
  // ------------------------------------------------------------
  assign off      = req_i.addr[TimerOffW-1:0];
  assign is_mtime = (off == TimerMtimeOff);
  assign is_cmp   = (off[1:0] == 2'b00) && (off >= TimerCmpOff) && (32'(off) < TimerCmpEnd);
  assign legal    = (is_mtime && !req_i.we) || is_cmp; // mtime is read-only
  assign cmp_sel  = HartIdxW'((off - TimerCmpOff) >> 2);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      err_q       <= 1'b0;
      timer_irq_q <= '0;
      for (int h = 0; h < NrHarts; h++) begin
        mtimecmp_q[h] <= '1;
      end
    end else begin
      err_q <= req_i.valid && !legal;
      if (req_i.valid && req_i.we && is_cmp) begin
        mtimecmp_q[cmp_sel] <= req_i.wdata;
      end
      for (int h = 0; h < NrHarts; h++) begin
        timer_irq_q[h] <= (mtime_q >= mtimecmp_q[h]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rdata_q <= is_mtime ? mtime_q : (is_cmp ? mtimecmp_q[cmp_sel] : '0);
    end
  end

  assign rdata_o     = rdata_q;
  assign err_o       = err_q;
  assign timer_irq_o = timer_irq_q;

endmodule

/* design/debug_req_gate.sv */
/*
 * Holds off per-hart debug requests for a fixed number of cycles after
 * reset so boot code runs before the first halt.
 */
`timescale 1ns/1ps

module debug_req_gate (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  subsys_pkg::hart_vec_t debug_req_i,
  output subsys_pkg::hart_vec_t debug_req_o
);
  import subsys_pkg::*;

  logic [DebugCntW-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= DebugCntW'(DebugDelayCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q != '0) ? '0 : debug_req_i; // open once drained

  a_masked: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (cnt_q != '0) |-> (debug_req_o == '0));

endmodule

/* design/resp_queue.sv */
/*
 * Response FIFO in front of the bus master.
 * Head entry is visible on the output; each pop returns one credit.
 * An empty queue passes the incoming response straight through.
 * Depth equals the credits the master holds after reset.
 */
`timescale 1ns/1ps

module resp_queue (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  subsys_pkg::bus_resp_t resp_i,
  input  logic                  resp_ready_i,
  output subsys_pkg::bus_resp_t resp_o,
  output logic                  credit_o
);
  import subsys_pkg::*;

  bus_resp_t        mem_q [RespDepth];
  logic [QPtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [QCntW-1:0] cnt_q;
  logic             push;
  logic             pop;
  logic             deq;
  logic             empty;
  logic             full;

  assign empty = (cnt_q == '0);
  assign full  = (cnt_q == QCntW'(RespDepth));

  always_comb begin
    if (empty) begin
      resp_o = resp_i; // bypass
    end else begin
      resp_o       = mem_q[rd_ptr_q];
      resp_o.valid = 1'b1;
    end
  end

  assign pop  = resp_o.valid && resp_ready_i;
  assign deq  = pop && !empty;
  assign push = resp_i.valid && !(empty && resp_ready_i); // no store when bypassed

  assign credit_o = pop;

  // ------------------------------------------------------------
  // pointers and fill level
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1; // depth is a power of two
      if (deq)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, deq})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= resp_i;
    end
  end

  // master with RespDepth credits can never overrun the queue
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    push |-> !full);

endmodule

/* design/cva6_subsys_top.sv */
/*
 * Top level of the request subsystem.
 * Connects the router to boot ROM, scratchpad and core timer, puts the
 * response queue in front of the master and gates the debug requests.
 */
`timescale 1ns/1ps

module cva6_subsys_top (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  rtc_i,
  input  subsys_pkg::bus_req_t  req_i,
  input  logic                  resp_ready_i,
  input  subsys_pkg::hart_vec_t debug_req_i,
  output subsys_pkg::bus_resp_t resp_o,
  output logic                  credit_o,
  output subsys_pkg::hart_vec_t debug_req_o,
  output subsys_pkg::hart_vec_t timer_irq_o
);
  import subsys_pkg::*;

  bus_req_t  rom_req, spm_req, timer_req;
  data_t     rom_rdata, spm_rdata, timer_rdata;
  logic      timer_err;
  bus_resp_t router_resp;

  // ------------------------------------------------------------
  // request path
  // ------------------------------------------------------------
  req_router i_req_router (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_i         ( req_i       ),
    .rom_rdata_i   ( rom_rdata   ),
    .spm_rdata_i   ( spm_rdata   ),
    .timer_rdata_i ( timer_rdata ),
    .timer_err_i   ( timer_err   ),
    .rom_req_o     ( rom_req     ),
    .spm_req_o     ( spm_req     ),
    .timer_req_o   ( timer_req   ),
    .resp_o        ( router_resp )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .rdata_o ( rom_rdata )
  );

  scratch_mem i_scratch_mem (
    .clk_i   ( clk_i     ),
    .req_i   ( spm_req   ),
    .rdata_o ( spm_rdata )
  );

  core_timer i_core_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( timer_req   ),
    .rdata_o     ( timer_rdata ),
    .err_o       ( timer_err   ),
    .timer_irq_o ( timer_irq_o )
  );

  resp_queue i_resp_queue (
    .clk_i        ( clk_i        ),
    .ndmreset_n   ( ndmreset_n   ),
    .resp_i       ( router_resp  ),
    .resp_ready_i ( resp_ready_i ),
    .resp_o       ( resp_o       ),
    .credit_o     ( credit_o     )
  );

  // ------------------------------------------------------------
  // debug
  // ------------------------------------------------------------
  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

/* test/tb_clk_gen.sv */
/*
 * Testbench clock and reset source.
 * 40 ns clock; reset is held low for two cycles, then released on a rising edge.
 */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o; // half of the 40 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* test/tb_subsys.sv */
/*
 * Trace-driven testbench for the request subsystem.
 * Reads operations and expected values from the trace file, tracks its
 * own credits and checks every response in request order.
 * Inputs change on rising edges and outputs are sampled on falling edges.
 */
`timescale 1ns/1ps

module tb_subsys;
  import subsys_pkg::*;

  localparam int    MaxOps    = 128;
  localparam string TraceFile = "test/subsys_trace.txt";

  // trace op codes
  localparam logic [3:0] OpRead   = 4'h1;
  localparam logic [3:0] OpWrite  = 4'h2;
  localparam logic [3:0] OpRtc    = 4'h3;
  localparam logic [3:0] OpDbgIn  = 4'h4;
  localparam logic [3:0] OpWait   = 4'h5;
  localparam logic [3:0] OpReady  = 4'h6;
  localparam logic [3:0] OpIrq    = 4'h7;
  localparam logic [3:0] OpDbgChk = 4'h8;
  localparam logic [3:0] OpDrain  = 4'h9;
  localparam logic [3:0] OpCredit = 4'hA;

  logic      clk;
  logic      rst_n;
  logic      rtc;
  bus_req_t  req;
  logic      resp_ready;
  hart_vec_t debug_req_in;
  bus_resp_t resp;
  logic      credit;
  hart_vec_t debug_req_out;
  hart_vec_t timer_irq;

  logic [3:0] op_a    [MaxOps];
  addr_t      addr_a  [MaxOps];
  data_t      wdata_a [MaxOps];
  data_t      rdata_a [MaxOps];
  logic       err_a   [MaxOps];
  bus_resp_t  exp_a   [MaxOps]; // expected responses, request order

  int n_ops        = 0;
  int n_sent       = 0;
  int n_recv       = 0;
  int credits_back = 0;
  int credit_mark  = 0;
  int cycle        = 0;
  int post_rst     = 0;
  int cycle_limit  = 0;

  tb_clk_gen i_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  cva6_subsys_top i_cva6_subsys_top (
    .clk_i        ( clk           ),
    .ndmreset_n   ( rst_n         ),
    .rtc_i        ( rtc           ),
    .req_i        ( req           ),
    .resp_ready_i ( resp_ready    ),
    .debug_req_i  ( debug_req_in  ),
    .resp_o       ( resp          ),
    .credit_o     ( credit        ),
    .debug_req_o  ( debug_req_out ),
    .timer_irq_o  ( timer_irq     )
  );

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  task automatic check_resp(input int idx, input bus_resp_t got, input bus_resp_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t ns: resp_o[%0d] got err=%0b rdata=%08h, %s",
        $time, idx, got.err, got.rdata,
        $sformatf("expected err=%0b rdata=%08h", exp.err, exp.rdata)));
    end
  endtask

  task automatic check_harts(input string name, input hart_vec_t got, input hart_vec_t exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t ns: %s got %04b, expected %04b",
        $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED at %0t ns: %s got %0b, expected %0b",
        $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_run($sformatf("CHECK FAILED at %0t ns: %s got %0d, expected %0d",
        $time, name, got, exp));
    end
  endtask

  // ------------------------------------------------------------
  // trace loading
  // ------------------------------------------------------------
  task automatic load_trace();
    int         fd;
    int         n;
    string      line;
    logic [3:0] op;
    addr_t      a;
    data_t      wd;
    data_t      rd;
    logic       e;
    fd = $fopen(TraceFile, "r");
    if (fd == 0) begin
      fail_run({"cannot open trace file ", TraceFile});
    end else begin
      while (!$feof(fd) && n_ops < MaxOps) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h", op, a, wd, rd, e);
          if (n != 5) begin
            fail_run($sformatf("trace line %0d does not have five fields", n_ops));
          end else begin
            op_a[n_ops]    = op;
            addr_a[n_ops]  = a;
            wdata_a[n_ops] = wd;
            rdata_a[n_ops] = rd;
            err_a[n_ops]   = e;
            n_ops++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ------------------------------------------------------------
  // drivers
  // ------------------------------------------------------------
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      req.valid <= 1'b0;
    end
  endtask

  task automatic send_req(input logic we, input addr_t addr, input data_t wdata,
                          input data_t exp_rdata, input logic exp_err);
    bus_req_t  r;
    bus_resp_t e;
    @(posedge clk);
    while (n_sent - credits_back >= RespDepth) begin // out of credits
      req.valid <= 1'b0;
      @(posedge clk);
    end
    r.valid = 1'b1;
    r.we    = we;
    r.addr  = addr;
    r.wdata = wdata;
    e.valid = 1'b1;
    e.err   = exp_err;
    e.rdata = exp_rdata;
    exp_a[n_sent] = e;
    req <= r;
    n_sent++;
  endtask

  // 2 cycles high, 3 low per rtc edge
  task automatic run_rtc(input int edges);
    repeat (edges) begin
      @(posedge clk);
      req.valid <= 1'b0;
      rtc       <= 1'b1;
      idle_cycles(2);
      rtc <= 1'b0;
      idle_cycles(2);
    end
  endtask

  task automatic wait_drain();
    while (n_recv < n_sent) idle_cycles(1);
  endtask

  task automatic check_debug_at(input int at_cycle, input hart_vec_t exp);
    @(negedge clk);
    while (post_rst < at_cycle) @(negedge clk);
    check_harts("debug_req_o", debug_req_out, exp);
  endtask

  task automatic run_op(input int i);
    case (op_a[i])
      OpRead:  send_req(1'b0, addr_a[i], '0, rdata_a[i], err_a[i]);
      OpWrite: send_req(1'b1, addr_a[i], wdata_a[i], rdata_a[i], err_a[i]);
      default: begin
        idle_cycles(1);
        case (op_a[i])
          OpRtc:    run_rtc(int'(wdata_a[i]));
          OpDbgIn:  debug_req_in <= wdata_a[i][NrHarts-1:0];
          OpWait:   idle_cycles(int'(wdata_a[i]));
          OpReady: begin
            resp_ready  <= wdata_a[i][0];
            credit_mark = credits_back;
          end
          OpIrq: begin
            @(negedge clk);
            check_harts("timer_irq_o", timer_irq, rdata_a[i][NrHarts-1:0]);
          end
          OpDbgChk: check_debug_at(int'(addr_a[i]), rdata_a[i][NrHarts-1:0]);
          OpDrain:  wait_drain();
          OpCredit: check_count("credit_o pulses", credits_back - credit_mark,
                                int'(rdata_a[i]));
          default:  fail_run($sformatf("unknown op %0h in trace entry %0d", op_a[i], i));
        endcase
      end
    endcase
  endtask

  // ------------------------------------------------------------
  // monitor and timeout
  // ------------------------------------------------------------
  always @(negedge clk) begin
    if (rst_n) begin
      if (credit) credits_back++;
      if (resp.valid && resp_ready) begin // taken on the next rising edge
        if (n_recv >= n_sent) begin
          fail_run("a response arrived with no request outstanding");
        end else begin
          check_resp(n_recv, resp, exp_a[n_recv]);
          n_recv++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle++;
    if (rst_n) post_rst++;
    if (cycle_limit > 0 && cycle > cycle_limit) begin
      fail_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    req          = '0;
    rtc          = 1'b0;
    resp_ready   = 1'b1;
    debug_req_in = '1;
    load_trace();
    cycle_limit = 20 * n_ops + DebugDelayCycles;
    wait (rst_n);
    @(negedge clk);
    check_flag("resp_o.valid", resp.valid, 1'b0);
    check_flag("credit_o", credit, 1'b0);
    check_harts("timer_irq_o", timer_irq, '0);
    check_harts("debug_req_o", debug_req_out, '0);
    for (int i = 0; i < n_ops; i++) begin
      run_op(i);
    end
    wait_drain();
    check_count("credit_o pulses in total", credits_back, n_recv);
    if (n_ops > 0) begin
      $display("Test OK");
      $finish;
    end else begin
      fail_run("the trace held no operations");
    end
  end

endmodule

/* test/subsys_trace.txt */
# columns: op addr wdata exp_rdata exp_err (hex)
# op 1 read, 2 write, 3 rtc edges, 4 debug in, 5 wait, 6 ready, 7 irq, 8 debug at cycle, 9 drain, a credits
4 00000000 00000005 00000000 0
8 00000028 00000000 00000000 0
# boot rom
1 00001000 00000000 b0070000 0
1 00001004 00000000 b0070001 0
1 00001010 00000000 b0070004 0
1 00001ffc 00000000 b00703ff 0
# scratchpad
2 80000000 12345678 00000000 0
2 80000004 cafef00d 00000000 0
2 800003fc a5a5a5a5 00000000 0
1 80000000 00000000 12345678 0
1 800003fc 00000000 a5a5a5a5 0
1 80000004 00000000 cafef00d 0
# error responses
1 40000000 00000000 00000000 1
2 40000000 deadbeef 00000000 1
1 00000ffc 00000000 00000000 1
1 80000400 00000000 00000000 1
2 00001008 11111111 00000000 1
2 02000000 00000007 00000000 1
1 02000018 00000000 00000000 1
1 02000002 00000000 00000000 1
# timer
1 02000000 00000000 00000000 0
1 02000004 00000000 ffffffff 0
3 00000000 00000006 00000000 0
5 00000000 00000008 00000000 0
1 02000000 00000000 00000003 0
2 0200000c 00000002 00000000 0
1 0200000c 00000000 00000002 0
9 00000000 00000000 00000000 0
5 00000000 00000004 00000000 0
7 00000000 00000000 00000004 0
# debug gate open
8 00000050 00000000 00000005 0
# back-pressure
9 00000000 00000000 00000000 0
6 00000000 00000000 00000000 0
1 00001000 00000000 b0070000 0
1 00001020 00000000 b0070008 0
1 00001040 00000000 b0070010 0
1 00001080 00000000 b0070020 0
5 00000000 00000006 00000000 0
a 00000000 00000000 00000000 0
6 00000000 00000001 00000000 0
9 00000000 00000000 00000000 0
a 00000000 00000000 00000004 0

/* build.f */
design/subsys_pkg.sv
design/req_router.sv
design/boot_rom.sv
design/scratch_mem.sv
design/core_timer.sv
design/debug_req_gate.sv
design/resp_queue.sv
design/cva6_subsys_top.sv
test/tb_clk_gen.sv
test/tb_subsys.sv

/* Makefile */
# Verilator build and run of the request subsystem testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_subsys
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard design/*.sv test/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "Test OK" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
